/* logic/bus_pkg.sv */
// bus and debug-word types shared by the debug FIFO, loader, decoder and memory bridge
`default_nettype none

package bus_pkg;

	// byte address and write data on the internal bus
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;

	// debug word from the host where bit 32 set means address load
	typedef logic [32:0] dbg_word_t;

	// one write request on the internal bus
	typedef struct packed {
		logic  valid;
		addr_t addr;
		data_t wdata;
	} bus_req_t;

	// debug FIFO sizing
	localparam int DBG_FIFO_DEPTH = 32;

	// pointer wraps naturally at the FIFO depth
	typedef logic [4:0] dbg_ptr_t;

endpackage

`default_nettype wire

/* logic/soc_regmap_pkg.sv */
// address map and misc register layout, imported by the decoder, misc registers and top level
`default_nettype none

package soc_regmap_pkg;

	// top nibble of the byte address selects the region
	typedef logic [3:0] region_t;

	localparam region_t REGION_MISC = 4'h2;
	localparam region_t REGION_MEM  = 4'h4;

	// word offset inside the misc region, address bits 5..2
	typedef logic [3:0] misc_off_t;

	localparam misc_off_t MISC_LED        = 4'd0;
	localparam misc_off_t MISC_PSRAMOVR_A = 4'd4;
	localparam misc_off_t MISC_FLASH_SEL  = 4'd11;

	typedef logic [8:0] led_t;

	// PSRAM pin override with enable in the top bit
	typedef struct packed {
		logic       enable;
		logic       oe;
		logic       sclk;
		logic       nce;
		logic [3:0] sout;
	} psram_ovr_t;

	// upper 24 bits of a flash-select write that queue the FPGA reload
	localparam logic [23:0] RELOAD_MAGIC = 24'hD0F1A5;

	// fsel_c is high while the countdown is in [FSEL_C_LO, FSEL_C_HI]
	localparam logic [2:0] FSEL_DELAY_START = 3'd7;
	localparam logic [2:0] FSEL_C_HI        = 3'd5;
	localparam logic [2:0] FSEL_C_LO        = 3'd3;

endpackage

`default_nettype wire

/* logic/dbg_fifo.sv */
// circular buffer between the host debug port and the loader, written by strobe, read by pop
`default_nettype none
`timescale 1ns/1ps

module dbg_fifo import bus_pkg::*; (
	input  wire       clk48m,
	input  wire       rst,
	input  wire       dbg_word_t push_word,
	input  wire       push,
	output dbg_word_t head,
	output logic      not_empty,
	input  wire       pop
);

	dbg_word_t mem [DBG_FIFO_DEPTH];
	dbg_ptr_t wr_ptr;
	dbg_ptr_t rd_ptr;
	// one bit wider than the pointer so full and empty differ
	logic [$bits(dbg_ptr_t):0] count;
	logic full;
	logic do_push;
	logic do_pop;

	assign full      = (count == DBG_FIFO_DEPTH);
	assign not_empty = (count != '0);
	assign head      = mem[rd_ptr];

	// a strobe into a full FIFO is lost since the host port has no back-pressure
	assign do_push = push && !full;
	assign do_pop  = pop && not_empty;

	always_ff @(posedge clk48m) begin
		if (do_push) begin
			mem[wr_ptr] <= push_word;
		end
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/dbg_loader.sv */
// bus master fed by the debug FIFO, loads the address or issues one write per data word
`default_nettype none
`timescale 1ns/1ps

module dbg_loader import bus_pkg::*; (
	input  wire       clk48m,
	input  wire       rst,
	input  wire       dbg_word_t head,
	input  wire       not_empty,
	output logic      pop,
	output bus_req_t  bus_req,
	input  wire       bus_ready
);

	typedef enum logic {
		ld_idle,
		ld_writing
	} ld_state_t;

	ld_state_t state;
	addr_t cur_addr;
	data_t wr_data;
	logic head_is_addr;

	assign head_is_addr = head[32];

	// a word is taken only while no write is outstanding
	assign pop = (state == ld_idle) && not_empty;

	always_comb begin
		bus_req.valid = (state == ld_writing);
		bus_req.addr  = cur_addr;
		bus_req.wdata = wr_data;
	end

	// payload register, only written on a data word
	always_ff @(posedge clk48m) begin
		if (pop && !head_is_addr) begin
			wr_data <= head[31:0];
		end
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			state    <= ld_idle;
			cur_addr <= '0;
		end else begin
			case (state)
				ld_idle: begin
					if (pop) begin
						if (head_is_addr) begin
							cur_addr <= head[31:0];
						end else begin
							state <= ld_writing;
						end
					end
				end
				ld_writing: begin
					// hold the request until the target accepts it, then step one word
					if (bus_ready) begin
						state    <= ld_idle;
						cur_addr <= cur_addr + 32'd4;
					end
				end
				default: state <= ld_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/bus_decoder.sv */
// routes each bus write by its address region and returns ready from the selected target
`default_nettype none
`timescale 1ns/1ps

module bus_decoder import bus_pkg::*, soc_regmap_pkg::*; (
	input  wire        clk48m,
	input  wire        rst,
	input  wire        bus_req_t bus_req,
	output logic       bus_ready,
	output logic       misc_we,
	output misc_off_t  misc_off,
	output data_t      misc_wdata,
	output bus_req_t   mem_bus,
	input  wire        mem_done,
	output logic       irq_bus_error
);

	region_t region;
	logic misc_sel;
	logic mem_sel;
	logic err_sel;

	always_comb begin
		region   = bus_req.addr[31:28];
		misc_sel = 1'b0;
		mem_sel  = 1'b0;
		err_sel  = 1'b0;
		if (bus_req.valid) begin
			case (region)
				REGION_MISC: misc_sel = 1'b1;
				REGION_MEM:  mem_sel  = 1'b1;
				default:     err_sel  = 1'b1;
			endcase
		end
	end

	// misc registers take the write in a single cycle
	assign misc_we    = misc_sel;
	assign misc_off   = bus_req.addr[5:2];
	assign misc_wdata = bus_req.wdata;

	always_comb begin
		mem_bus.valid = mem_sel;
		mem_bus.addr  = bus_req.addr;
		mem_bus.wdata = bus_req.wdata;
	end

	// unmapped writes are acknowledged at once so the loader moves on
	assign bus_ready = misc_sel || err_sel || (mem_sel && mem_done);

	// one pulse per unmapped write since valid drops right after ready
	always_ff @(posedge clk48m) begin
		if (rst) begin
			irq_bus_error <= 1'b0;
		end else begin
			irq_bus_error <= err_sel;
		end
	end

endmodule

`default_nettype wire

/* logic/misc_regs.sv */
// misc register block in region 0x2: LEDs, PSRAM-A pin override, flash select and reload
`default_nettype none
`timescale 1ns/1ps

module misc_regs import bus_pkg::*, soc_regmap_pkg::*; (
	input  wire        clk48m,
	input  wire        rst,
	input  wire        we,
	input  wire        misc_off_t off,
	input  wire        data_t wdata,
	output led_t       led,
	output logic       psram_sclk,
	output logic       psram_nce,
	output logic       psram_oe,
	output logic [3:0] psram_sout,
	output logic       fsel_d,
	output logic       fsel_c,
	output logic       programn
);

	psram_ovr_t ovr;
	logic [2:0] fsel_cnt;
	logic reload_queued;
	logic reload;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led           <= '0;
			ovr           <= '0;
			fsel_d        <= 1'b0;
			reload_queued <= 1'b0;
		end else if (we) begin
			case (off)
				MISC_LED:        led <= wdata[$bits(led_t)-1:0];
				MISC_PSRAMOVR_A: ovr <= wdata[$bits(psram_ovr_t)-1:0];
				MISC_FLASH_SEL: begin
					fsel_d <= wdata[0];
					// reload only fires when the magic is in the upper bits
					if (wdata[31:8] == RELOAD_MAGIC) begin
						reload_queued <= 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

	// pins sit at idle levels when not overridden
	assign psram_oe   = ovr.enable ? ovr.oe   : 1'b0;
	assign psram_sclk = ovr.enable ? ovr.sclk : 1'b0;
	assign psram_nce  = ovr.enable ? ovr.nce  : 1'b1;
	assign psram_sout = ovr.enable ? ovr.sout : 4'b0000;

	// give the flash mux flop time to settle before PROGRAMN is pulled
	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_cnt <= '0;
			reload   <= 1'b0;
		end else if (we && off == MISC_FLASH_SEL) begin
			fsel_cnt <= FSEL_DELAY_START;
		end else if (fsel_cnt != '0) begin
			fsel_cnt <= fsel_cnt - 1'b1;
			if (fsel_cnt == 3'd1 && reload_queued) begin
				reload <= 1'b1;
			end
		end
	end

	// three-cycle clock pulse for the flash-select flop
	assign fsel_c = (fsel_cnt <= FSEL_C_HI) && (fsel_cnt >= FSEL_C_LO);

	// reload is sticky until reset
	assign programn = ~reload;

endmodule

`default_nettype wire

/* logic/mem_port_bridge.sv */
// four-phase req/ack master that forwards region 0x4 writes to the external memory port
`default_nettype none
`timescale 1ns/1ps

module mem_port_bridge import bus_pkg::*; (
	input  wire      clk48m,
	input  wire      rst,
	input  wire      bus_req_t mem_bus,
	output logic     mem_done,
	output logic     mem_req,
	output addr_t    mem_addr,
	output data_t    mem_wdata,
	input  wire      mem_ack
);

	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_release,
		st_done
	} br_state_t;

	br_state_t state;

	// address and data stay stable for the whole handshake
	always_ff @(posedge clk48m) begin
		if (state == st_idle && mem_bus.valid) begin
			mem_addr  <= mem_bus.addr;
			mem_wdata <= mem_bus.wdata;
		end
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (mem_bus.valid) begin
						state <= st_request;
					end
				end
				st_request: begin
					if (mem_ack) begin
						state <= st_release;
					end
				end
				st_release: begin
					// wait for the responder to drop ack before reporting done
					if (!mem_ack) begin
						state <= st_done;
					end
				end
				st_done: state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	assign mem_req  = (state == st_request);
	assign mem_done = (state == st_done);

endmodule

`default_nettype wire

/* logic/soc_debug_top.sv */
// top level of the debug-register path, connects host port, loader, decoder and targets
`default_nettype none
`timescale 1ns/1ps

module soc_debug_top import bus_pkg::*, soc_regmap_pkg::*; (
	input  wire        clk48m,
	input  wire        rst,
	input  wire        data_t dbg_in,
	input  wire        dbg_sel,
	input  wire        dbg_strobe,
	output wire        mem_req,
	output wire        addr_t mem_addr,
	output wire        data_t mem_wdata,
	input  wire        mem_ack,
	output wire        led_t led,
	output wire        psram_sclk,
	output wire        psram_nce,
	output wire        psram_oe,
	output wire  [3:0] psram_sout,
	output wire        fsel_d,
	output wire        fsel_c,
	output wire        programn,
	output wire        irq_bus_error
);

	dbg_word_t fifo_head;
	logic fifo_not_empty;
	logic fifo_pop;
	bus_req_t bus_req;
	logic bus_ready;
	logic misc_we;
	misc_off_t misc_off;
	data_t misc_wdata;
	bus_req_t mem_bus;
	logic mem_done;

	dbg_fifo fifo_i (
		.clk48m    (clk48m),
		.rst       (rst),
		.push_word ({dbg_sel, dbg_in}),
		.push      (dbg_strobe),
		.head      (fifo_head),
		.not_empty (fifo_not_empty),
		.pop       (fifo_pop)
	);

	dbg_loader loader_i (
		.clk48m    (clk48m),
		.rst       (rst),
		.head      (fifo_head),
		.not_empty (fifo_not_empty),
		.pop       (fifo_pop),
		.bus_req   (bus_req),
		.bus_ready (bus_ready)
	);

	bus_decoder decoder_i (
		.clk48m        (clk48m),
		.rst           (rst),
		.bus_req       (bus_req),
		.bus_ready     (bus_ready),
		.misc_we       (misc_we),
		.misc_off      (misc_off),
		.misc_wdata    (misc_wdata),
		.mem_bus       (mem_bus),
		.mem_done      (mem_done),
		.irq_bus_error (irq_bus_error)
	);

	misc_regs misc_i (
		.clk48m     (clk48m),
		.rst        (rst),
		.we         (misc_we),
		.off        (misc_off),
		.wdata      (misc_wdata),
		.led        (led),
		.psram_sclk (psram_sclk),
		.psram_nce  (psram_nce),
		.psram_oe   (psram_oe),
		.psram_sout (psram_sout),
		.fsel_d     (fsel_d),
		.fsel_c     (fsel_c),
		.programn   (programn)
	);

	mem_port_bridge bridge_i (
		.clk48m    (clk48m),
		.rst       (rst),
		.mem_bus   (mem_bus),
		.mem_done  (mem_done),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_ack   (mem_ack)
	);

endmodule

`default_nettype wire

/* dv/soc_debug_properties.sv */
// concurrent checks on the debug path top level, attached to soc_debug_top by a bind
`default_nettype none
`timescale 1ns/1ps

module soc_debug_properties import bus_pkg::*; (
	input wire clk48m,
	input wire rst,
	input wire dbg_strobe,
	input wire fifo_pop,
	input wire mem_req,
	input wire mem_ack,
	input wire irq_bus_error,
	input wire programn
);

	// FIFO fill level as seen from the host port
	logic [5:0] fill;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			fill <= '0;
		end else begin
			fill <= fill + 6'(dbg_strobe && fill != 6'(DBG_FIFO_DEPTH)) - 6'(fifo_pop);
		end
	end

	// request stays up until the responder answers
	req_held: assert property (@(posedge clk48m) disable iff (rst)
		mem_req && !mem_ack |=> mem_req)
		else $error("mem_req dropped before mem_ack");

	no_push_when_full: assert property (@(posedge clk48m) disable iff (rst)
		dbg_strobe |-> fill != 6'(DBG_FIFO_DEPTH))
		else $error("debug strobe while the FIFO is full");

	irq_single_cycle: assert property (@(posedge clk48m) disable iff (rst)
		irq_bus_error |=> !irq_bus_error)
		else $error("irq_bus_error longer than one cycle");

	programn_sticky: assert property (@(posedge clk48m) disable iff (rst)
		!programn |=> !programn)
		else $error("programn returned high after the reload");

endmodule

`default_nettype wire

/* dv/tb_soc_debug.sv */
// testbench for the debug path, streams a table of debug words and checks every target
`default_nettype none
`timescale 1ns/1ps

module tb_soc_debug import bus_pkg::*, soc_regmap_pkg::*; ();

	typedef struct packed {
		logic       sel;
		data_t      payload;
		logic [7:0] gap;
	} stim_t;

	typedef struct packed {
		addr_t addr;
		data_t data;
	} mem_wr_t;

	typedef struct packed {
		logic       oe;
		logic       sclk;
		logic       nce;
		logic [3:0] sout;
	} pins_t;

	typedef struct packed {
		logic fsel_d;
		logic reload;
	} fsel_wr_t;

	logic clk48m = 1'b0;
	logic rst;
	data_t dbg_in;
	logic dbg_sel;
	logic dbg_strobe;
	logic mem_req;
	addr_t mem_addr;
	data_t mem_wdata;
	logic mem_ack;
	led_t led;
	logic psram_sclk;
	logic psram_nce;
	logic psram_oe;
	logic [3:0] psram_sout;
	logic fsel_d;
	logic fsel_c;
	logic programn;
	logic irq_bus_error;

	// select, payload, idle cycles after the strobe
	stim_t stim_table [23] = '{
		'{1'b1, 32'h4000_0100, 8'd0},
		'{1'b0, 32'h1111_0001, 8'd0},
		'{1'b0, 32'h2222_0002, 8'd0},
		'{1'b0, 32'h3333_0003, 8'd0},
		'{1'b0, 32'h4444_0004, 8'd50},
		'{1'b1, 32'h2000_0000, 8'd0},
		'{1'b0, 32'h0000_01A5, 8'd0},
		'{1'b1, 32'h2000_0000, 8'd0},
		'{1'b0, 32'hFFFF_FE5A, 8'd0},
		'{1'b1, 32'h2000_0010, 8'd0},
		'{1'b0, 32'h0000_00E5, 8'd0},
		'{1'b1, 32'h2000_0010, 8'd0},
		'{1'b0, 32'h0000_006A, 8'd0},
		'{1'b1, 32'h9000_0000, 8'd0},
		'{1'b0, 32'hDEAD_0001, 8'd0},
		'{1'b0, 32'hDEAD_0002, 8'd0},
		'{1'b1, 32'h4000_0800, 8'd0},
		'{1'b0, 32'hCAFE_0005, 8'd0},
		'{1'b0, 32'h0BAD_0006, 8'd30},
		'{1'b1, 32'h2000_002C, 8'd0},
		'{1'b0, 32'h0000_0001, 8'd12},
		'{1'b1, 32'h2000_002C, 8'd0},
		'{1'b0, 32'hD0F1_A500, 8'd0}
	};

	mem_wr_t mem_exp [$];
	led_t led_exp [$];
	pins_t pins_exp [$];
	fsel_wr_t fsel_exp [$];
	pins_t pins_idle = '{1'b0, 1'b0, 1'b1, 4'h0};
	int exp_errors = 0;
	logic exp_programn = 1'b1;
	int errors = 0;
	int checks = 0;
	int irq_count = 0;
	int cycles = 0;
	logic [15:0] lfsr_state = 16'd60;
	led_t led_prev = '0;
	pins_t pins_prev = '{1'b0, 1'b0, 1'b1, 4'h0};
	logic fsel_c_prev = 1'b0;
	logic programn_prev = 1'b1;
	int fsel_width = 0;
	fsel_wr_t cur_fsel = '0;
	logic reload_due = 1'b0;

	soc_debug_top dut_i (
		.clk48m        (clk48m),
		.rst           (rst),
		.dbg_in        (dbg_in),
		.dbg_sel       (dbg_sel),
		.dbg_strobe    (dbg_strobe),
		.mem_req       (mem_req),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.mem_ack       (mem_ack),
		.led           (led),
		.psram_sclk    (psram_sclk),
		.psram_nce     (psram_nce),
		.psram_oe      (psram_oe),
		.psram_sout    (psram_sout),
		.fsel_d        (fsel_d),
		.fsel_c        (fsel_c),
		.programn      (programn),
		.irq_bus_error (irq_bus_error)
	);

	bind soc_debug_top soc_debug_properties props_i (
		.clk48m        (clk48m),
		.rst           (rst),
		.dbg_strobe    (dbg_strobe),
		.fifo_pop      (fifo_pop),
		.mem_req       (mem_req),
		.mem_ack       (mem_ack),
		.irq_bus_error (irq_bus_error),
		.programn      (programn)
	);

	always #10 clk48m = ~clk48m;

	function automatic void check_value(input string name, input logic [63:0] exp_val,
		input logic [63:0] act_val);
		checks++;
		assert (act_val === exp_val) else begin
			$display("Fail at %0t ns: %s expected %0h, got %0h",
				$time, name, exp_val, act_val);
			errors++;
		end
	endfunction

	function automatic bit has_pending(input int n, input string what);
		assert (n != 0) else begin
			$display("Error at %0t ns: %s seen with nothing left to expect", $time, what);
			errors++;
		end
		return n != 0;
	endfunction

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// two LFSR bits give an ack delay of 0 to 3 cycles
	task automatic draw_delay(output int unsigned d);
		d = 0;
		repeat (2) begin
			d = (d << 1) | 32'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// walk the table the way the loader does and queue what each target should see
	function automatic void build_expectations();
		addr_t addr;
		data_t d;
		pins_t p;
		addr = '0;
		foreach (stim_table[i]) begin
			d = stim_table[i].payload;
			if (stim_table[i].sel) begin
				addr = d;
			end else begin
				case (addr[31:28])
					REGION_MEM: mem_exp.push_back('{addr, d});
					REGION_MISC: begin
						if (addr[5:2] == MISC_LED) begin
							led_exp.push_back(d[8:0]);
						end else if (addr[5:2] == MISC_PSRAMOVR_A) begin
							p = pins_idle;
							if (d[7]) begin
								p.oe   = d[6];
								p.sclk = d[5];
								p.nce  = d[4];
								p.sout = d[3:0];
							end
							pins_exp.push_back(p);
						end else if (addr[5:2] == MISC_FLASH_SEL) begin
							fsel_exp.push_back('{d[0], d[31:8] == RELOAD_MAGIC});
							if (d[31:8] == RELOAD_MAGIC) begin
								exp_programn = 1'b0;
							end
						end
					end
					default: exp_errors++;
				endcase
				addr = addr + 32'd4;
			end
		end
	endfunction

	// the strobe rises 2 ns after an edge and is seen at the next edge
	task automatic send_word(input stim_t s);
		dbg_sel    = s.sel;
		dbg_in     = s.payload;
		dbg_strobe = 1'b1;
		@(posedge clk48m);
		#2;
		dbg_strobe = 1'b0;
		repeat (s.gap) begin
			@(posedge clk48m);
			#2;
		end
	endtask

	function automatic bit all_seen();
		return mem_exp.size() == 0 && led_exp.size() == 0 && pins_exp.size() == 0 &&
			fsel_exp.size() == 0 && !fsel_c_prev && irq_count == exp_errors &&
			programn_prev == exp_programn;
	endfunction

	// memory port responder with random ack delays
	initial begin
		int unsigned delay;
		mem_wr_t exp_wr;
		mem_ack = 1'b0;
		forever begin
			@(posedge clk48m);
			#1;
			if (!rst && mem_req && !mem_ack) begin
				if (has_pending(mem_exp.size(), "mem_req")) begin
					exp_wr = mem_exp.pop_front();
					check_value("mem_addr", 64'(exp_wr.addr), 64'(mem_addr));
					check_value("mem_wdata", 64'(exp_wr.data), 64'(mem_wdata));
				end
				draw_delay(delay);
				#1;
				repeat (delay) begin
					@(posedge clk48m);
					#2;
				end
				mem_ack = 1'b1;
				do begin
					@(posedge clk48m);
					#1;
				end while (mem_req);
				draw_delay(delay);
				#1;
				repeat (delay) begin
					@(posedge clk48m);
					#2;
				end
				mem_ack = 1'b0;
			end
		end
	end

	// register outputs and the interrupt are sampled 1 ns after each edge
	always begin
		pins_t pins_now;
		@(posedge clk48m);
		#1;
		pins_now = {psram_oe, psram_sclk, psram_nce, psram_sout};
		if (!rst) begin
			if (irq_bus_error) begin
				irq_count++;
			end
			if (led !== led_prev && has_pending(led_exp.size(), "led change")) begin
				check_value("led", 64'(led_exp.pop_front()), 64'(led));
			end
			led_prev = led;
			if (pins_now !== pins_prev &&
				has_pending(pins_exp.size(), "psram pin change")) begin
				check_value("psram pins", 64'(pins_exp.pop_front()), 64'(pins_now));
			end
			pins_prev = pins_now;
			if (fsel_c) begin
				fsel_width++;
			end
			if (fsel_c && !fsel_c_prev && has_pending(fsel_exp.size(), "fsel_c pulse")) begin
				cur_fsel = fsel_exp.pop_front();
				check_value("fsel_d", 64'(cur_fsel.fsel_d), 64'(fsel_d));
				check_value("programn", 64'd1, 64'(programn));
			end
			if (!fsel_c && fsel_c_prev) begin
				check_value("fsel_c width", 64'd3, 64'(fsel_width));
				fsel_width = 0;
				reload_due = reload_due | cur_fsel.reload;
			end
			fsel_c_prev = fsel_c;
			if (!programn && programn_prev) begin
				assert (reload_due) else begin
					$display("Error at %0t ns: programn fell without a reload write", $time);
					errors++;
				end
			end
			programn_prev = programn;
		end
	end

	// run limit grows with the table
	initial begin
		while (cycles < $size(stim_table) * 40 + 200) begin
			@(posedge clk48m);
			cycles++;
		end
		$display("Error: timeout, the table did not complete within %0d cycles", cycles);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		rst        = 1'b1;
		dbg_in     = '0;
		dbg_sel    = 1'b0;
		dbg_strobe = 1'b0;
		build_expectations();
		repeat (16) @(posedge clk48m);
		#2;
		rst = 1'b0;
		check_value("mem_req", 64'd0, 64'(mem_req));
		check_value("irq_bus_error", 64'd0, 64'(irq_bus_error));
		check_value("fsel_c", 64'd0, 64'(fsel_c));
		check_value("programn", 64'd1, 64'(programn));
		check_value("led", 64'd0, 64'(led));
		check_value("psram pins", 64'(pins_idle),
			64'({psram_oe, psram_sclk, psram_nce, psram_sout}));
		foreach (stim_table[i]) begin
			send_word(stim_table[i]);
		end
		while (!all_seen()) begin
			@(posedge clk48m);
		end
		// extra cycles to catch stray pulses or requests
		repeat (8) @(posedge clk48m);
		#1;
		check_value("irq_bus_error pulses", 64'(exp_errors), 64'(irq_count));
		check_value("programn", 64'(exp_programn), 64'(programn));
		$display("checks %0d, errors %0d, bus errors %0d", checks, errors, irq_count);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
logic/bus_pkg.sv
logic/soc_regmap_pkg.sv
logic/dbg_fifo.sv
logic/dbg_loader.sv
logic/bus_decoder.sv
logic/misc_regs.sv
logic/mem_port_bridge.sv
logic/soc_debug_top.sv
dv/soc_debug_properties.sv
dv/tb_soc_debug.sv

/* run.sh */
#!/bin/sh
# builds the debug path testbench with Verilator, runs it and checks the log for the verdict

cd "$(dirname "$0")" || exit 1

if ! mkdir -p build; then
	echo "could not create the build directory"
	exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module tb_soc_debug -Mdir build/obj_dir; then
	echo "verilator build failed"
	exit 1
fi

./build/obj_dir/Vtb_soc_debug > build/sim.log 2>&1
status=$?
cat build/sim.log

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation PASSED$" build/sim.log; then
	exit 0
fi
echo "pass message not found in build/sim.log"
exit 1
